// ==== build.f ====
+incdir+include
design/xlate_pkg.sv
design/xlate_cfg_if.sv
design/xlate_apb_regs.sv
design/eva_to_npa.sv
design/xlate_req_fsm.sv
design/xlate_class_counters.sv
design/xlate_top.sv
testbench/xlate_props.sv
testbench/xlate_checker.sv
testbench/xlate_tb.sv

// ==== Makefile ====
# Verilator build for the address translation stage
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = xlate_tb
FILELIST   = build.f
LOG        = sim.log
SIM_ARGS   = +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/xlate_tb.sv ====
// translation stage testbench
// APB config, random requests with stalls, reference model and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "xlate_config.svh"

module xlate_tb;
  localparam int N_RAND  = 40;               // random requests per test
  localparam int NUM_REQ = 4 * N_RAND + 2;   // plus directed ones
  localparam int LIMIT   = NUM_REQ * 40 + 2000;

  logic        clk, reset;
  logic [7:0]  paddr;
  logic        psel, penable, pwrite;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;
  logic        req_valid, req_ready, resp_valid, resp_ready;
  logic [31:0] eva;
  logic [3:0]  x_cord, y_cord;
  logic [15:0] epa;
  logic        invalid;

  logic [2:0]  test_id;
  logic [24:0] exp_npa;
  logic [31:0] exp_rdata;
  logic        exp_err;
  logic        stall_en;
  logic [31:0] rnd, stall_rnd;  // lcg states
  logic [3:0]  m_tgo_x, m_tgo_y, m_dx, m_dy;  // config model
  logic        m_dram_en;
  int          cnt_model [5];
  int          n_sent, errors, resps, total;

  xlate_top dut0 (
    .clk_i (clk), .reset_i (reset),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .eva_i (eva),
    .resp_valid_o (resp_valid), .resp_ready_i (resp_ready),
    .x_cord_o (x_cord), .y_cord_o (y_cord), .epa_o (epa), .invalid_o (invalid)
  );

  xlate_checker chk0 (
    .clk_i (clk), .reset_i (reset), .test_id_i (test_id),
    .req_valid_i (req_valid), .req_ready_i (req_ready),
    .resp_valid_i (resp_valid), .resp_ready_i (resp_ready),
    .npa_i ({x_cord, y_cord, epa, invalid}), .exp_npa_i (exp_npa),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .pslverr_i (pslverr),
    .prdata_i (prdata), .exp_rdata_i (exp_rdata), .exp_err_i (exp_err),
    .errors_o (errors), .resps_o (resps)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // upper halves of two steps, low lcg bits are weak
  function automatic logic [31:0] rand32();
    logic [31:0] r;
    rnd      = lcg(rnd);
    r[31:16] = rnd[31:16];
    rnd      = lcg(rnd);
    r[15:0]  = rnd[31:16];
    return r;
  endfunction

  function automatic logic [31:0] make_eva(input int kind, input logic [31:0] r);
    case (kind)
      0:       return {2'b01, r[29:0]};     // global
      1:       return {3'b001, r[28:0]};    // tile group
      2:       return {5'b00001, r[26:0]};  // shared
      3:       return {1'b1, r[30:0]};      // dram, any
      4:       return {2'b11, r[29:0]};     // host window
      5:       return {2'b10, r[29:0]};     // block mode
      default: return {5'b00000, r[26:0]};  // unmapped
    endcase
  endfunction

  // expected {x, y, epa, invalid} and class index
  function automatic logic [24:0] xlate_ref(input logic [31:0] a, output int cls);
    logic [3:0]  x, y;
    logic [15:0] e;
    logic [25:0] blk;
    logic [31:0] ofs, sx, sy, loc;
    x = '0;
    y = '0;
    e = '0;
    cls = 4;
    if (a[31]) begin
      cls = 0;
      if (m_dram_en) begin
        blk = a[30:5];         // line number, bank in low 4 bits
        x   = {1'b0, blk[2:0]};
        y   = {4{blk[3]}};
        e   = {blk[16:4], a[4:2]};
      end else if (a[30]) begin
        y = 4'd1;
        e = {1'b1, a[16:2]};
      end else begin
        x = {1'b0, a[14:12]};
        y = {4{a[15]}};
        e = {6'd0, a[11:2]};
      end
    end else if (a[31:30] == 2'b01) begin
      cls = 1;
      x   = a[21:18];
      y   = a[27:24];
      e   = a[17:2];
    end else if (a[31:29] == 3'b001) begin
      cls = 2;
      x   = a[21:18] + m_tgo_x;  // mod 16
      y   = a[27:24] + m_tgo_y;
      e   = a[17:2];
    end else if (a[31:27] == 5'b00001) begin
      cls = 3;
      ofs = {7'd0, a[26:2]};
      sx  = ofs & ((32'd1 << m_dx) - 32'd1);
      sy  = (ofs >> m_dx) & ((32'd1 << m_dy) - 32'd1);
      loc = ofs >> (32'(m_dx) + 32'(m_dy));
      x   = sx[3:0] + m_tgo_x;
      y   = sy[3:0] + m_tgo_y;
      e   = loc[15:0] + `XLATE_DMEM_START;
    end
    return {x, y, e, cls == 4};
  endfunction

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          input logic [31:0] rdata_exp, input logic err_exp);
    @(posedge clk);
    psel      <= 1'b1;  // setup
    penable   <= 1'b0;
    pwrite    <= wr;
    paddr     <= addr;
    pwdata    <= wdata;
    exp_rdata <= rdata_exp;
    exp_err   <= err_exp;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);      // access sampled here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    apb_xfer(1'b1, addr, data, 32'd0, 1'b0);
  endtask

  task automatic reg_read(input logic [7:0] addr, input logic [31:0] data);
    apb_xfer(1'b0, addr, 32'd0, data, 1'b0);
  endtask

  task automatic write_cfg(input logic [3:0] tx, ty, dx, dy, input logic den);
    reg_write(`XLATE_REG_TGO, {24'd0, ty, tx});
    reg_write(`XLATE_REG_DIM, {24'd0, dy, dx});
    reg_write(`XLATE_REG_CTRL, {31'd0, den});
    m_tgo_x   = tx;
    m_tgo_y   = ty;
    m_dx      = dx;
    m_dy      = dy;
    m_dram_en = den;
  endtask

  task automatic send_req(input logic [31:0] a);
    int          cls;
    logic [24:0] exp;
    exp = xlate_ref(a, cls);
    @(posedge clk);
    req_valid <= 1'b1;
    eva       <= a;
    exp_npa   <= exp;
    do @(posedge clk); while (!req_ready);  // accepted at this edge
    req_valid <= 1'b0;
    do @(posedge clk); while (!(resp_valid && resp_ready));
    if (cnt_model[cls] < 65535) cnt_model[cls]++;
    n_sent++;
  endtask

  // random back-pressure, about one stall in four
  always @(posedge clk) begin
    if (stall_en) begin
      stall_rnd = lcg(stall_rnd);
      resp_ready <= (stall_rnd[31:30] != 2'b00);
    end else begin
      resp_ready <= 1'b1;
    end
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    req_valid = 1'b0;
    eva = '0;
    resp_ready = 1'b1;
    stall_en = 1'b0;
    test_id = '0;
    exp_npa = '0;
    exp_rdata = '0;
    exp_err = 1'b0;
    rnd = 32'd43;
    stall_rnd = 32'd43;
    {m_tgo_x, m_tgo_y, m_dx, m_dy, m_dram_en} = '0;
    n_sent = 0;
    for (int k = 0; k < 5; k++) cnt_model[k] = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    test_id <= 3'd1;  // tgo redrawn every 8 requests
    for (int i = 0; i < N_RAND; i++) begin
      r = rand32();
      if (i % 8 == 0) write_cfg(r[3:0], r[7:4], 4'd0, 4'd0, 1'b0);
      send_req(make_eva(i % 2, rand32()));
    end
    write_cfg(4'hF, 4'hE, 4'd0, 4'd0, 1'b0);
    send_req(32'h2308_0010);  // x 2 y 3, both wrap to 1

    test_id <= 3'd2;
    for (int i = 0; i < N_RAND; i++) begin
      r = rand32();
      if (i % 8 == 0) write_cfg(r[3:0], r[7:4], {2'b00, r[9:8]}, {2'b00, r[11:10]}, 1'b0);
      send_req(make_eva(2, rand32()));
    end

    test_id <= 3'd3;
    write_cfg(m_tgo_x, m_tgo_y, m_dx, m_dy, 1'b1);  // striped
    for (int i = 0; i < 14; i++) send_req(make_eva(3, rand32()));
    write_cfg(m_tgo_x, m_tgo_y, m_dx, m_dy, 1'b0);  // host window and block mode
    for (int i = 0; i < 14; i++) send_req(make_eva(4 + i % 2, rand32()));
    for (int i = 0; i < 12; i++) send_req(make_eva(6, rand32()));

    test_id  <= 3'd4;
    stall_en <= 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      r = rand32();
      send_req(make_eva(int'(r[15:0]) % 7, rand32()));
    end
    stall_en <= 1'b0;

    test_id <= 3'd5;
    for (int k = 0; k < 5; k++) reg_read(8'(`XLATE_REG_CNT_BASE + 4 * k), 32'(cnt_model[k]));
    write_cfg(4'h5, 4'hA, 4'h1, 4'h2, 1'b1);
    reg_read(`XLATE_REG_TGO, 32'hA5);
    reg_read(`XLATE_REG_DIM, 32'h21);
    reg_read(`XLATE_REG_CTRL, 32'h1);
    apb_xfer(1'b1, 8'h0C, 32'h1, 32'd0, 1'b1);  // unmapped
    apb_xfer(1'b0, 8'h24, 32'd0, 32'd0, 1'b1);  // past the count window
    apb_xfer(1'b1, 8'h10, 32'h7, 32'd0, 1'b1);  // counts are read only
    apb_xfer(1'b0, 8'h13, 32'd0, 32'd0, 1'b1);  // misaligned
    reg_write(`XLATE_REG_CTRL, 32'h3);          // clear, dram_en stays
    for (int k = 0; k < 5; k++) cnt_model[k] = 0;
    reg_read(`XLATE_REG_CTRL, 32'h1);
    for (int k = 0; k < 5; k++) reg_read(8'(`XLATE_REG_CNT_BASE + 4 * k), 32'd0);
    send_req(make_eva(0, rand32()));
    reg_read(8'(`XLATE_REG_CNT_BASE + 4), 32'd1);

    repeat (4) @(posedge clk);
    total = errors + dut0.props0.fail_cnt;
    if (resps != n_sent) begin
      total++;
      $display("response count %0d does not match requests sent %0d", resps, n_sent);
    end
    $display("requests %0d, responses %0d, check errors %0d, assertion failures %0d",
             n_sent, resps, errors, dut0.props0.fail_cnt);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/xlate_checker.sv ====
// translation checker
// compares responses and APB accesses and checks latency and handshakes
`timescale 1ns/1ps
`default_nettype none

module xlate_checker (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [2:0]  test_id_i,
  input  logic        req_valid_i,
  input  logic        req_ready_i,
  input  logic        resp_valid_i,
  input  logic        resp_ready_i,
  input  logic [24:0] npa_i,       // {x, y, epa, invalid}
  input  logic [24:0] exp_npa_i,   // model result for the outstanding request
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic        pslverr_i,
  input  logic [31:0] prdata_i,
  input  logic [31:0] exp_rdata_i,
  input  logic        exp_err_i,
  output int          errors_o,
  output int          resps_o
);
  logic pending = 1'b0;  // request accepted and not yet answered
  logic seen    = 1'b0;  // valid already observed
  int   lat     = 0;
  int   errors  = 0;
  int   resps   = 0;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "global_tile_group";
      3'd2:    return "shared";
      3'd3:    return "dram_invalid";
      3'd4:    return "stall";
      3'd5:    return "apb";
      default: return "setup";
    endcase
  endfunction

  always @(posedge clk_i) begin
    if (reset_i) begin
      pending = 1'b0;
      seen    = 1'b0;
    end else begin
      // ready only while idle
      if (req_ready_i !== !pending) begin
        errors++;
        $display("[ERROR] %s: req_ready expected %b actual %b",
                 test_name(test_id_i), !pending, req_ready_i);
      end
      if (pending && !seen) begin
        lat++;
        if (resp_valid_i) begin
          seen = 1'b1;
          if (lat != 2) begin
            errors++;
            $display("[ERROR] %s: latency expected 2 actual %0d", test_name(test_id_i), lat);
          end
        end
      end else if (!pending && resp_valid_i) begin
        errors++;
        $display("%s: response valid with no request outstanding", test_name(test_id_i));
      end
      if (resp_valid_i && resp_ready_i) begin
        resps++;  // duplicates counted too
        if (pending && npa_i !== exp_npa_i) begin
          errors++;
          $display("[ERROR] %s: npa expected %h actual %h",
                   test_name(test_id_i), exp_npa_i, npa_i);
        end
        pending = 1'b0;
      end
      if (req_valid_i && req_ready_i) begin
        pending = 1'b1;
        seen    = 1'b0;
        lat     = 0;
      end
      // apb access phase
      if (psel_i && penable_i) begin
        if (pslverr_i !== exp_err_i) begin
          errors++;
          $display("[ERROR] %s: pslverr expected %b actual %b",
                   test_name(test_id_i), exp_err_i, pslverr_i);
        end
        if (!pwrite_i && !exp_err_i && prdata_i !== exp_rdata_i) begin
          errors++;
          $display("[ERROR] %s: prdata expected %h actual %h",
                   test_name(test_id_i), exp_rdata_i, prdata_i);
        end
      end
    end
  end

  assign errors_o = errors;
  assign resps_o  = resps;

endmodule

`default_nettype wire

// ==== testbench/xlate_props.sv ====
// handshake assertions for the translation stage
// bound to the top level, counts its own failures
`timescale 1ns/1ps
`default_nettype none

module xlate_props (
  input logic        clk_i,
  input logic        reset_i,
  input logic        req_valid_i,
  input logic        req_ready_i,
  input logic        resp_valid_i,
  input logic        resp_ready_i,
  input logic [24:0] npa_i,       // {x, y, epa, invalid}
  input logic        pready_i
);
  int fail_cnt = 0;  // read by the testbench at the end

  // response and result held under back-pressure
  resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(npa_i))
    else begin
      fail_cnt++;
      $error("response dropped or changed while stalled");
    end

  // valid rises two edges after the accept
  resp_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(resp_valid_i) |-> $past(req_valid_i && req_ready_i, 2))
    else begin
      fail_cnt++;
      $error("response valid not two cycles after accept");
    end

  pready_high: assert property (@(posedge clk_i) pready_i)
    else begin
      fail_cnt++;
      $error("pready low");
    end
endmodule

bind xlate_top xlate_props props0 (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .req_valid_i  (req_valid_i),
  .req_ready_i  (req_ready_o),
  .resp_valid_i (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .npa_i        ({x_cord_o, y_cord_o, epa_o, invalid_o}),
  .pready_i     (pready_o)
);

`default_nettype wire

// ==== design/xlate_top.sv ====
// address translation stage top
// APB config, request FSM and class counters on plain ports
`timescale 1ns/1ps
`default_nettype none

module xlate_top
  import xlate_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [7:0]       paddr_i,
  input  logic             psel_i,
  input  logic             penable_i,
  input  logic             pwrite_i,
  input  logic [31:0]      pwdata_i,
  output logic [31:0]      prdata_o,
  output logic             pready_o,
  output logic             pslverr_o,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  logic [31:0]      eva_i,
  output logic             resp_valid_o,
  input  logic             resp_ready_i,
  output logic [X_W-1:0]   x_cord_o,
  output logic [Y_W-1:0]   y_cord_o,
  output logic [EPA_W-1:0] epa_o,
  output logic             invalid_o
);
  logic                              clear;
  logic [NUM_CLASSES-1:0][CNT_W-1:0] counts;
  logic                              count_fire;
  xlate_class_e                      count_class;
  npa_s                              npa;

  xlate_cfg_if cfg_if ();

  xlate_apb_regs regs0 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg       (cfg_if.regs),
    .clear_o   (clear),
    .counts_i  (counts)
  );

  xlate_req_fsm fsm0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .eva_i         (eva_i),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .npa_o         (npa),
    .cfg           (cfg_if.xlate),
    .count_fire_o  (count_fire),
    .count_class_o (count_class)
  );

  xlate_class_counters cnt0 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .fire_i   (count_fire),
    .class_i  (count_class),
    .clear_i  (clear),
    .counts_o (counts)
  );

  // npa fields out as plain ports
  assign x_cord_o  = npa.x_cord;
  assign y_cord_o  = npa.y_cord;
  assign epa_o     = npa.epa;
  assign invalid_o = npa.invalid;

endmodule

`default_nettype wire

// ==== design/xlate_class_counters.sv ====
// per-class translation counters
// saturating, synchronous clear beats increment
`timescale 1ns/1ps
`default_nettype none

module xlate_class_counters
  import xlate_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              fire_i,
  input  xlate_class_e                      class_i,
  input  logic                              clear_i,
  output logic [NUM_CLASSES-1:0][CNT_W-1:0] counts_o
);
  logic [NUM_CLASSES-1:0][CNT_W-1:0] counts_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      counts_q <= '0;
    end else if (fire_i) begin
      for (int k = 0; k < NUM_CLASSES; k++) begin
        // stick at all ones
        if (class_i == xlate_class_e'(k) && counts_q[k] != '1) begin
          counts_q[k] <= counts_q[k] + 1'b1;
        end
      end
    end
  end

  assign counts_o = counts_q;

endmodule

`default_nettype wire

// ==== design/xlate_req_fsm.sv ====
// translation request FSM
// one request at a time, IDLE -> XLATE -> RESP
`timescale 1ns/1ps
`default_nettype none

module xlate_req_fsm
  import xlate_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  input  logic [31:0]  eva_i,
  output logic         resp_valid_o,
  input  logic         resp_ready_i,
  output npa_s         npa_o,
  xlate_cfg_if.xlate   cfg,
  output logic         count_fire_o,
  output xlate_class_e count_class_o
);
  typedef enum logic [1:0] {IDLE, XLATE, RESP} state_e;

  state_e       state_q;
  logic [31:0]  eva_q;     // latched on accept
  npa_s         npa_d, npa_q;
  xlate_class_e class_d, class_q;
  logic         resp_fire;

  eva_to_npa xlate0 (
    .eva_i     (eva_q),
    .tgo_x_i   (cfg.tgo_x),  // config sampled in XLATE
    .tgo_y_i   (cfg.tgo_y),
    .dim_x_w_i (cfg.dim_x_w),
    .dim_y_w_i (cfg.dim_y_w),
    .dram_en_i (cfg.dram_en),
    .npa_o     (npa_d),
    .class_o   (class_d)
  );

  assign req_ready_o  = (state_q == IDLE);
  assign resp_valid_o = (state_q == RESP);
  assign resp_fire    = resp_valid_o & resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (req_valid_i) state_q <= XLATE;
        XLATE:   state_q <= RESP;
        RESP:    if (resp_ready_i) state_q <= IDLE;  // held under back-pressure
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_ready_o && req_valid_i) eva_q <= eva_i;
    if (state_q == XLATE) begin
      npa_q   <= npa_d;
      class_q <= class_d;
    end
  end

  assign npa_o         = npa_q;
  assign count_fire_o  = resp_fire;  // count on transfer
  assign count_class_o = class_q;

endmodule

`default_nettype wire

// ==== design/eva_to_npa.sv ====
// EVA to NPA mapping
// classifies the EVA and maps DRAM, global, tile-group and shared space
`timescale 1ns/1ps
`default_nettype none

module eva_to_npa
  import xlate_pkg::*;
(
  input  logic [31:0]    eva_i,      // byte addr
  input  logic [X_W-1:0] tgo_x_i,
  input  logic [Y_W-1:0] tgo_y_i,
  input  logic [X_W-1:0] dim_x_w_i,
  input  logic [Y_W-1:0] dim_y_w_i,
  input  logic           dram_en_i,
  output npa_s           npa_o,
  output xlate_class_e   class_o
);
  global_addr_s            global_addr;
  tile_group_addr_s        tg_addr;
  shared_addr_s            shared_addr;
  logic                    is_dram, is_global, is_tg, is_shared;
  logic [DRAM_BLK_W-1:0]   dram_block;
  logic [BANK_W-1:0]       bank;
  logic [SHARED_OFS_W-1:0] shared_x, shared_y, shared_hi, shared_local;

  assign global_addr = eva_i;
  assign tg_addr     = eva_i;
  assign shared_addr = eva_i;

  assign is_dram   = eva_i[31];
  assign is_global = (global_addr.remote == 2'b01);
  assign is_tg     = (tg_addr.remote == 3'b001);
  assign is_shared = (shared_addr.remote == 5'b00001);

  // power-of-two bank slice, line granularity
  assign dram_block = eva_i[2+BLK_OFS_W +: DRAM_BLK_W];
  assign bank       = dram_block[BANK_W-1:0];

  // shared split: low dim_x_w bits -> x, next dim_y_w -> y, rest local
  assign shared_x     = shared_addr.offset & ~({SHARED_OFS_W{1'b1}} << dim_x_w_i);
  assign shared_hi    = shared_addr.offset >> dim_x_w_i;
  assign shared_y     = shared_hi & ~({SHARED_OFS_W{1'b1}} << dim_y_w_i);
  assign shared_local = shared_hi >> dim_y_w_i;

  always_comb begin
    npa_o   = '0;       // unmapped -> zero npa
    class_o = INVALID;
    if (is_dram) begin
      class_o = DRAM;
      if (dram_en_i) begin
        npa_o.x_cord = X_W'(bank[TILE_X_W-1:0]);
        npa_o.y_cord = bank[BANK_W-1] ? '1 : '0;  // bottom vcache row
        npa_o.epa    = EPA_W'({dram_block >> BANK_W, eva_i[2 +: BLK_OFS_W]});
      end else if (eva_i[30]) begin
        npa_o.x_cord = '0;  // host window
        npa_o.y_cord = Y_W'(1);
        npa_o.epa    = {1'b1, eva_i[2 +: EPA_W-1]};
      end else begin
        // block memory, one vcache per LG_VC_SIZE words
        npa_o.x_cord = X_W'(eva_i[2+LG_VC_SIZE +: TILE_X_W]);
        npa_o.y_cord = eva_i[2+LG_VC_SIZE+TILE_X_W] ? '1 : '0;
        npa_o.epa    = EPA_W'(eva_i[2 +: LG_VC_SIZE]);
      end
    end else if (is_global) begin
      class_o      = GLOBAL;
      npa_o.x_cord = X_W'(global_addr.x_cord);  // truncated to mesh width
      npa_o.y_cord = Y_W'(global_addr.y_cord);
      npa_o.epa    = global_addr.addr;
    end else if (is_tg) begin
      class_o      = TILE_GROUP;
      npa_o.x_cord = X_W'(tg_addr.x_cord + tgo_x_i);  // wraps
      npa_o.y_cord = Y_W'(tg_addr.y_cord + tgo_y_i);
      npa_o.epa    = tg_addr.addr;
    end else if (is_shared) begin
      class_o      = SHARED;
      npa_o.x_cord = X_W'(shared_x + tgo_x_i);
      npa_o.y_cord = Y_W'(shared_y + tgo_y_i);
      npa_o.epa    = EPA_W'(shared_local + DMEM_START);  // into DMEM
    end else begin
      npa_o.invalid = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/xlate_apb_regs.sv ====
// APB slave for translation config
// holds TGO, DIM, CTRL and returns the class counts
`timescale 1ns/1ps
`default_nettype none
`include "xlate_config.svh"

module xlate_apb_regs
  import xlate_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [7:0]                          paddr_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [31:0]                         pwdata_i,
  output logic [31:0]                         prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  xlate_cfg_if.regs                           cfg,
  output logic                                clear_o,
  input  logic [NUM_CLASSES-1:0][CNT_W-1:0]   counts_i
);
  logic           access;   // access phase
  logic           wr_ok;
  logic           hit_tgo, hit_dim, hit_ctrl, hit_cnt;
  logic [7:0]     cnt_ofs;
  logic [2:0]     cnt_idx;  // class index of count reg
  logic [X_W-1:0] tgo_x_q;
  logic [Y_W-1:0] tgo_y_q;
  logic [X_W-1:0] dim_x_w_q;
  logic [Y_W-1:0] dim_y_w_q;
  logic           dram_en_q;
  logic           clear_q;

  assign access   = psel_i & penable_i;
  assign pready_o = 1'b1;   // no wait states

  assign hit_tgo  = (paddr_i == `XLATE_REG_TGO);
  assign hit_dim  = (paddr_i == `XLATE_REG_DIM);
  assign hit_ctrl = (paddr_i == `XLATE_REG_CTRL);
  assign cnt_ofs  = paddr_i - `XLATE_REG_CNT_BASE;
  assign cnt_idx  = cnt_ofs[4:2];
  // word aligned, inside the count window
  assign hit_cnt  = (paddr_i >= `XLATE_REG_CNT_BASE) && (paddr_i[1:0] == 2'b00)
                 && (cnt_ofs < 8'(4 * NUM_CLASSES));

  // unmapped offset, or a write to a read-only count
  assign pslverr_o = access & (~(hit_tgo | hit_dim | hit_ctrl | hit_cnt)
                               | (pwrite_i & hit_cnt));
  assign wr_ok = access & pwrite_i & ~pslverr_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tgo_x_q   <= '0;
      tgo_y_q   <= '0;
      dim_x_w_q <= '0;
      dim_y_w_q <= '0;
      dram_en_q <= 1'b0;
      clear_q   <= 1'b0;
    end else begin
      clear_q <= wr_ok & hit_ctrl & pwdata_i[1];  // one-cycle pulse
      if (wr_ok && hit_tgo) begin
        tgo_x_q <= pwdata_i[3:0];
        tgo_y_q <= pwdata_i[7:4];
      end
      if (wr_ok && hit_dim) begin
        dim_x_w_q <= pwdata_i[3:0];
        dim_y_w_q <= pwdata_i[7:4];
      end
      if (wr_ok && hit_ctrl) dram_en_q <= pwdata_i[0];
    end
  end

  // read mux, clear bit reads back 0
  always_comb begin
    prdata_o = '0;
    if (hit_tgo)       prdata_o[7:0] = {tgo_y_q, tgo_x_q};
    else if (hit_dim)  prdata_o[7:0] = {dim_y_w_q, dim_x_w_q};
    else if (hit_ctrl) prdata_o[0]   = dram_en_q;
    else if (hit_cnt)  prdata_o      = 32'(counts_i[cnt_idx]);
  end

  assign clear_o     = clear_q;
  assign cfg.tgo_x   = tgo_x_q;
  assign cfg.tgo_y   = tgo_y_q;
  assign cfg.dim_x_w = dim_x_w_q;
  assign cfg.dim_y_w = dim_y_w_q;
  assign cfg.dram_en = dram_en_q;

endmodule

`default_nettype wire

// ==== design/xlate_cfg_if.sv ====
// live translation config
// APB registers to the translator
`timescale 1ns/1ps
`default_nettype none

interface xlate_cfg_if
  import xlate_pkg::*;
();
  logic [X_W-1:0] tgo_x;    // tile-group origin
  logic [Y_W-1:0] tgo_y;
  logic [X_W-1:0] dim_x_w;  // clog2 of group dim x
  logic [Y_W-1:0] dim_y_w;
  logic           dram_en;  // striped DRAM mode

  modport regs (output tgo_x, tgo_y, dim_x_w, dim_y_w, dram_en);
  modport xlate (input tgo_x, tgo_y, dim_x_w, dim_y_w, dram_en);
endinterface

`default_nettype wire

// ==== design/xlate_pkg.sv ====
// translation types
// EVA layouts, address class and NPA result
`default_nettype none
`include "xlate_config.svh"

package xlate_pkg;

  localparam int X_W          = `XLATE_X_W;
  localparam int Y_W          = `XLATE_Y_W;
  localparam int EPA_W        = `XLATE_EPA_W;
  localparam int CNT_W        = `XLATE_CNT_W;
  localparam int NUM_CLASSES  = 5;
  localparam int TILE_X_W     = $clog2(`XLATE_NUM_TILES_X);     // 3
  localparam int BANK_W       = TILE_X_W + 1;                   // {bot_not_top, x}
  localparam int BLK_OFS_W    = $clog2(`XLATE_VC_BLOCK_WORDS);  // word in line
  localparam int LG_VC_SIZE   = $clog2(`XLATE_VC_SIZE_WORDS);
  localparam int DRAM_BLK_W   = 32 - 1 - 2 - BLK_OFS_W;         // eva 30..5
  localparam int SHARED_OFS_W = 25;
  localparam logic [EPA_W-1:0] DMEM_START = `XLATE_DMEM_START;

  typedef enum logic [2:0] {
    DRAM       = 3'd0,
    GLOBAL     = 3'd1,
    TILE_GROUP = 3'd2,
    SHARED     = 3'd3,
    INVALID    = 3'd4
  } xlate_class_e;

  typedef struct packed {
    logic [1:0]  remote;    // 2'b01
    logic [5:0]  y_cord;
    logic [5:0]  x_cord;
    logic [15:0] addr;      // word addr
    logic [1:0]  byte_ofs;
  } global_addr_s;

  typedef struct packed {
    logic [2:0]  remote;    // 3'b001
    logic [4:0]  y_cord;    // relative to origin
    logic [5:0]  x_cord;
    logic [15:0] addr;
    logic [1:0]  byte_ofs;
  } tile_group_addr_s;

  typedef struct packed {
    logic [4:0]              remote;  // 5'b00001
    logic [SHARED_OFS_W-1:0] offset;  // interleaved word offset
    logic [1:0]              byte_ofs;
  } shared_addr_s;

  typedef struct packed {
    logic [X_W-1:0]   x_cord;
    logic [Y_W-1:0]   y_cord;
    logic [EPA_W-1:0] epa;
    logic             invalid;
  } npa_s;

endpackage

`default_nettype wire

// ==== include/xlate_config.svh ====
// address translation config
// widths, mesh and vcache geometry, APB register offsets
`ifndef XLATE_CONFIG_SVH
`define XLATE_CONFIG_SVH

`define XLATE_X_W            4      // x cord width
`define XLATE_Y_W            4      // y cord width
`define XLATE_EPA_W          16     // endpoint word addr width
`define XLATE_NUM_TILES_X    8      // power of two only
`define XLATE_VC_BLOCK_WORDS 8      // vcache line in words
`define XLATE_VC_SIZE_WORDS  1024   // vcache capacity in words
`define XLATE_DMEM_START     16'h400

`define XLATE_CNT_W          16

// APB byte offsets
`define XLATE_REG_TGO        8'h00
`define XLATE_REG_DIM        8'h04
`define XLATE_REG_CTRL       8'h08
`define XLATE_REG_CNT_BASE   8'h10

`endif
